// File: n64_load_pkg.sv
`default_nettype none

package n64_load_pkg;

	// ======================================================================
	// Download bus and word widths
	// ======================================================================

	// Byte address on the host bus, also the RAM byte address
	localparam int DL_ADDR_W  = 27;
	localparam int DL_HALF_W  = 16;
	localparam int WORD_W     = 32;
	localparam int INDEX_W    = 8;
	localparam int PIF_ADDR_W = 10;

	// ======================================================================
	// Target selection
	// ======================================================================

	// Low index bits pick the target, the bit just above is the PIF bank
	localparam int TGT_SEL_W = 6;

	localparam logic [TGT_SEL_W-1:0] TGT_PIF  = 6'd0;
	localparam logic [TGT_SEL_W-1:0] TGT_CART = 6'd1;

	// Cartridge image sits 8 MiB into external RAM
	localparam logic [DL_ADDR_W-1:0] CART_BASE = 27'h080_0000;

	typedef enum logic [1:0] {
		LOAD_PIF  = 2'd0,
		LOAD_CART = 2'd1,
		LOAD_NONE = 2'd2
	} load_target_t;

endpackage

`default_nettype wire

// File: load_word_if.sv
`timescale 1ns/100ps
`default_nettype none

// Assembled 32-bit words from the capture stage
interface load_word_if;
	import n64_load_pkg::*;

	// One-cycle strobe, the receiver cannot stall it
	logic                 valid;
	load_target_t         target;
	// Byte address of the first half
	logic [DL_ADDR_W-1:0] addr;
	logic                 bank;
	logic [WORD_W-1:0]    data;

	modport source (
		output valid,
		output target,
		output addr,
		output bank,
		output data
	);

	modport sink (
		input valid,
		input target,
		input addr,
		input bank,
		input data
	);

endinterface

`default_nettype wire

// File: ram_write_if.sv
`timescale 1ns/100ps
`default_nettype none

// Cartridge write channel to external RAM
interface ram_write_if;
	import n64_load_pkg::*;

	// req pulses once, ready pulses once when the write is done
	logic                 req;
	logic [DL_ADDR_W-1:0] addr;
	logic [WORD_W-1:0]    data;
	logic                 ready;

	modport source (
		output req,
		output addr,
		output data,
		input  ready
	);

	// Transaction tracking on the RAM side
	modport monitor (
		input  req,
		output ready
	);

endinterface

`default_nettype wire

// File: load_capture.sv
`timescale 1ns/100ps
`default_nettype none

module load_capture (
	input  logic                               clk_1x,
	input  logic                               rst,
	input  logic                               ioctl_download,
	input  logic [n64_load_pkg::INDEX_W-1:0]   ioctl_index,
	input  logic [n64_load_pkg::DL_ADDR_W-1:0] ioctl_addr,
	input  logic [n64_load_pkg::DL_HALF_W-1:0] ioctl_dout,
	input  logic                               ioctl_wr,
	output logic                               cart_download,
	load_word_if.source                        words
);
	import n64_load_pkg::*;

	load_target_t         target_d;
	load_target_t         target_q;
	logic [TGT_SEL_W-1:0] sel;
	logic                 half_wr;
	logic [DL_HALF_W-1:0] half_q;
	logic [DL_ADDR_W-1:0] addr_q;
	logic                 bank_q;

	// ======================================================================
	// Target decode, one cycle behind the host
	// ======================================================================

	assign sel = ioctl_index[TGT_SEL_W-1:0];

	always_comb begin
		target_d = LOAD_NONE;
		if (ioctl_download) begin
			if (sel == TGT_PIF)
				target_d = LOAD_PIF;
			else if (sel == TGT_CART)
				target_d = LOAD_CART;
		end
	end

	always_ff @(posedge clk_1x) begin
		if (rst)
			target_q <= LOAD_NONE;
		else
			target_q <= target_d;
	end

	assign cart_download = (target_q == LOAD_CART);

	// ======================================================================
	// Half joining
	// ======================================================================

	assign half_wr = ioctl_wr && (target_q != LOAD_NONE);

	always_ff @(posedge clk_1x) begin
		if (rst)
			words.valid <= 1'b0;
		else
			words.valid <= half_wr && ioctl_addr[1];
	end

	always_ff @(posedge clk_1x) begin
		if (half_wr) begin
			if (!ioctl_addr[1]) begin
				half_q <= ioctl_dout;
				addr_q <= ioctl_addr;
				bank_q <= ioctl_index[TGT_SEL_W];
			end else begin
				words.target <= target_q;
				words.addr   <= addr_q;
				words.bank   <= bank_q;
				// PIF ROM is big endian within each half
				if (target_q == LOAD_PIF)
					words.data <= {half_q[7:0], half_q[15:8], ioctl_dout[7:0], ioctl_dout[15:8]};
				else
					words.data <= {ioctl_dout, half_q};
			end
		end
	end

	// Host keeps the download open past the last second half
	a_valid_in_download: assert property (@(posedge clk_1x) disable iff (rst)
		words.valid |-> (target_q != LOAD_NONE));

endmodule

`default_nettype wire

// File: load_router.sv
`timescale 1ns/100ps
`default_nettype none

module load_router (
	input  logic                                clk_1x,
	input  logic                                rst,
	input  logic                                cart_download,
	load_word_if.sink                           words,
	output logic [n64_load_pkg::PIF_ADDR_W-1:0] pifrom_wraddress,
	output logic [n64_load_pkg::WORD_W-1:0]     pifrom_wrdata,
	output logic                                pifrom_wren,
	ram_write_if.source                         ram,
	output logic                                cart_loaded
);
	import n64_load_pkg::*;

	logic pif_word;
	logic cart_word;

	assign pif_word  = words.valid && (words.target == LOAD_PIF);
	assign cart_word = words.valid && (words.target == LOAD_CART);

	// ======================================================================
	// Strobes and the sticky loaded flag
	// ======================================================================

	always_ff @(posedge clk_1x) begin
		if (rst) begin
			pifrom_wren <= 1'b0;
			ram.req     <= 1'b0;
			cart_loaded <= 1'b0;
		end else begin
			pifrom_wren <= pif_word;
			ram.req     <= cart_word;
			// Stays set until the next reset
			if (cart_download)
				cart_loaded <= 1'b1;
		end
	end

	// ======================================================================
	// Address mapping
	// ======================================================================

	// Bank bit on top of the word address inside a 2 KiB bank
	always_ff @(posedge clk_1x) begin
		if (pif_word) begin
			pifrom_wraddress <= {words.bank, words.addr[PIF_ADDR_W:2]};
			pifrom_wrdata    <= words.data;
		end
	end

	always_ff @(posedge clk_1x) begin
		if (cart_word) begin
			ram.addr <= words.addr + CART_BASE;
			ram.data <= words.data;
		end
	end

endmodule

`default_nettype wire

// File: cart_ram_writer.sv
`timescale 1ns/100ps
`default_nettype none

module cart_ram_writer (
	input  logic         clk_1x,
	input  logic         rst,
	input  logic         cart_download,
	ram_write_if.monitor ram,
	input  logic         ram_ready,
	output logic         ioctl_wait
);

	logic txn_open_q;

	assign ram.ready = ram_ready;

	// ======================================================================
	// Open transaction and host stall
	// ======================================================================

	always_ff @(posedge clk_1x) begin
		if (rst)
			txn_open_q <= 1'b0;
		else if (ram.req)
			txn_open_q <= 1'b1;
		else if (ram.ready)
			txn_open_q <= 1'b0;
	end

	// Rises with the request itself, released once the flag drops
	assign ioctl_wait = cart_download && (ram.req || txn_open_q);

	// Host stall must keep the router from issuing a second write
	a_single_txn: assert property (@(posedge clk_1x) disable iff (rst)
		ram.req |-> !txn_open_q);

	// RAM acknowledges only writes it was given
	a_ready_with_txn: assert property (@(posedge clk_1x) disable iff (rst)
		ram.ready |-> txn_open_q);

endmodule

`default_nettype wire

// File: n64_loader_top.sv
`timescale 1ns/100ps
`default_nettype none

module n64_loader_top (
	input  logic                                clk_1x,
	input  logic                                rst,
	input  logic                                ioctl_download,
	input  logic [n64_load_pkg::INDEX_W-1:0]    ioctl_index,
	input  logic [n64_load_pkg::DL_ADDR_W-1:0]  ioctl_addr,
	input  logic [n64_load_pkg::DL_HALF_W-1:0]  ioctl_dout,
	input  logic                                ioctl_wr,
	output logic                                ioctl_wait,
	output logic [n64_load_pkg::PIF_ADDR_W-1:0] pifrom_wraddress,
	output logic [n64_load_pkg::WORD_W-1:0]     pifrom_wrdata,
	output logic                                pifrom_wren,
	output logic [n64_load_pkg::DL_ADDR_W-1:0]  ram_addr,
	output logic [n64_load_pkg::WORD_W-1:0]     ram_data,
	output logic                                ram_req,
	input  logic                                ram_ready,
	output logic                                cart_download,
	output logic                                cart_loaded
);

	load_word_if words ();
	ram_write_if ram ();

	load_capture u_capture (
		.clk_1x         (clk_1x),
		.rst            (rst),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.ioctl_wr       (ioctl_wr),
		.cart_download  (cart_download),
		.words          (words.source)
	);

	load_router u_router (
		.clk_1x           (clk_1x),
		.rst              (rst),
		.cart_download    (cart_download),
		.words            (words.sink),
		.pifrom_wraddress (pifrom_wraddress),
		.pifrom_wrdata    (pifrom_wrdata),
		.pifrom_wren      (pifrom_wren),
		.ram              (ram.source),
		.cart_loaded      (cart_loaded)
	);

	cart_ram_writer u_writer (
		.clk_1x        (clk_1x),
		.rst           (rst),
		.cart_download (cart_download),
		.ram           (ram.monitor),
		.ram_ready     (ram_ready),
		.ioctl_wait    (ioctl_wait)
	);

	// RAM channel out to the pins
	assign ram_addr = ram.addr;
	assign ram_data = ram.data;
	assign ram_req  = ram.req;

endmodule

`default_nettype wire

// File: tb_clock_gen.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen (
	input  logic reset_req,
	output logic clk_1x,
	output logic rst
);

	logic por;

	// 40 ns period, power-on reset for two cycles
	initial begin
		clk_1x = 1'b0;
		por = 1'b1;
		repeat (2) @(posedge clk_1x);
		#2 por = 1'b0;
	end

	always #20 clk_1x = ~clk_1x;

	assign rst = por || reset_req;

endmodule

`default_nettype wire

// File: n64_loader_tb.sv
`timescale 1ns/100ps
`default_nettype none

module n64_loader_tb;
	import n64_load_pkg::*;

	localparam int MAX_STALL   = 6;
	// Edges per word, a PIF word never stalls
	localparam int PIF_WORD    = 4;
	localparam int CART_WORD   = 5 + MAX_STALL;
	// Index setup and the tail after the last word
	localparam int DL_EXTRA    = 7;
	localparam int TEST_CYCLES = 12 + 2 * (8 * PIF_WORD + DL_EXTRA)
		+ (8 * CART_WORD + DL_EXTRA) + (16 * CART_WORD + DL_EXTRA)
		+ (4 * PIF_WORD + DL_EXTRA) + 3 + (4 * PIF_WORD + DL_EXTRA);
	localparam int TIMEOUT = 2 * TEST_CYCLES + MAX_STALL;

	logic clk_1x, rst, reset_req;
	logic ioctl_download, ioctl_wr, ioctl_wait, ram_ready, ram_req;
	logic [INDEX_W-1:0] ioctl_index;
	logic [DL_ADDR_W-1:0] ioctl_addr, ram_addr;
	logic [DL_HALF_W-1:0] ioctl_dout;
	logic [PIF_ADDR_W-1:0] pifrom_wraddress;
	logic [WORD_W-1:0] pifrom_wrdata, ram_data;
	logic pifrom_wren, cart_download, cart_loaded;

	// Predicted write, presented with the second half
	logic pred_pif, pred_cart, pif_d1, pif_d2, cart_d1, cart_d2;
	logic [DL_ADDR_W-1:0] pred_addr, addr_d1, addr_d2;
	logic [WORD_W-1:0] pred_data, data_d1, data_d2;
	logic model_cart_q, model_loaded, txn_open;
	logic [DL_ADDR_W+WORD_W:0] exp_q[$];
	logic [DL_ADDR_W+WORD_W:0] exp_w, got_w;
	string test_name;
	int errors, tests, cycles, seed;

	tb_clock_gen u_clk (.reset_req(reset_req), .clk_1x(clk_1x), .rst(rst));

	n64_loader_top DUT (.*);

	task automatic report_error(input string msg);
		errors++;
		$display("%s", msg);
	endtask

	// ======================================================================
	// Reference model
	// ======================================================================

	always @(posedge clk_1x) begin
		{pif_d1, cart_d1, addr_d1, data_d1} <= {pred_pif, pred_cart, pred_addr, pred_data};
		{pif_d2, cart_d2, addr_d2, data_d2} <= {pif_d1, cart_d1, addr_d1, data_d1};
		if (rst) begin
			model_cart_q <= 1'b0;
			model_loaded <= 1'b0;
			txn_open <= 1'b0;
		end else begin
			model_cart_q <= ioctl_download && (ioctl_index[TGT_SEL_W-1:0] == TGT_CART);
			model_loaded <= model_loaded || model_cart_q;
			// Open from the predicted request until the RAM model acknowledges
			if (cart_d2)
				txn_open <= 1'b1;
			else if (ram_ready)
				txn_open <= 1'b0;
		end
		if (!rst && (pifrom_wren || ram_req)) begin
			if (exp_q.size() == 0) begin
				report_error($sformatf("Write appeared with no predicted write in test %s",
					test_name));
			end else begin
				exp_w = exp_q.pop_front();
				if (ram_req)
					got_w = {1'b1, ram_addr, ram_data};
				else
					got_w = {1'b0, {(DL_ADDR_W - PIF_ADDR_W){1'b0}}, pifrom_wraddress,
						pifrom_wrdata};
				a_write_order: assert (got_w == exp_w)
					else report_error($sformatf("CHECK FAILED %s write expected %h actual %h",
						test_name, exp_w, got_w));
			end
		end
	end

	// ======================================================================
	// Checks
	// ======================================================================

	a_pif_wren: assert property (@(posedge clk_1x) disable iff (rst) pifrom_wren == pif_d2)
		else report_error($sformatf("CHECK FAILED %s pifrom_wren expected %b actual %b",
			test_name, pif_d2, pifrom_wren));
	a_pif_word: assert property (@(posedge clk_1x) disable iff (rst) pifrom_wren |->
		(pifrom_wrdata == data_d2 && pifrom_wraddress == addr_d2[PIF_ADDR_W-1:0]))
		else report_error($sformatf("CHECK FAILED %s pif expected %h@%h actual %h@%h",
			test_name, data_d2, addr_d2[PIF_ADDR_W-1:0], pifrom_wrdata, pifrom_wraddress));
	a_ram_req: assert property (@(posedge clk_1x) disable iff (rst) ram_req == cart_d2)
		else report_error($sformatf("CHECK FAILED %s ram_req expected %b actual %b",
			test_name, cart_d2, ram_req));
	a_ram_word: assert property (@(posedge clk_1x) disable iff (rst) ram_req |->
		(ram_data == data_d2 && ram_addr == addr_d2))
		else report_error($sformatf("CHECK FAILED %s ram expected %h@%h actual %h@%h",
			test_name, data_d2, addr_d2, ram_data, ram_addr));
	a_wait: assert property (@(posedge clk_1x) disable iff (rst)
		ioctl_wait == (model_cart_q && (cart_d2 || txn_open)))
		else report_error($sformatf("CHECK FAILED %s ioctl_wait expected %b actual %b",
			test_name, model_cart_q && (cart_d2 || txn_open), ioctl_wait));
	a_flags: assert property (@(posedge clk_1x) disable iff (rst)
		cart_download == model_cart_q && cart_loaded == model_loaded)
		else report_error($sformatf("CHECK FAILED %s flags expected %b%b actual %b%b",
			test_name, model_cart_q, model_loaded, cart_download, cart_loaded));
	a_no_wr_in_wait: assert property (@(posedge clk_1x) disable iff (rst)
		ioctl_wait |-> !ioctl_wr)
		else report_error("Host wrote a half while the wait was high");
	a_single_req: assert property (@(posedge clk_1x) disable iff (rst) ram_req |-> !txn_open)
		else report_error("RAM request issued while a write was still open");

	// RAM model, acknowledge after 1 to 6 cycles
	initial begin
		ram_ready = 1'b0;
		forever begin
			@(posedge clk_1x);
			#1;
			if (ram_req) begin
				repeat ($urandom % MAX_STALL + 1) @(posedge clk_1x);
				#2 ram_ready = 1'b1;
				@(posedge clk_1x);
				#2 ram_ready = 1'b0;
			end
		end
	end

	always @(posedge clk_1x) begin
		cycles++;
		if (cycles >= TIMEOUT) begin
			$display("Run stopped after %0d cycles without finishing", cycles);
			$display("Test failed");
			$finish;
		end
	end

	// ======================================================================
	// Stimulus
	// ======================================================================

	task automatic send_word(input logic [DL_ADDR_W-1:0] a, input logic [WORD_W-1:0] d);
		logic [TGT_SEL_W-1:0] sel;
		sel = ioctl_index[TGT_SEL_W-1:0];
		@(posedge clk_1x);
		#2 {ioctl_wr, ioctl_addr, ioctl_dout} = {1'b1, a, d[15:0]};
		@(posedge clk_1x);
		#2 {ioctl_addr, ioctl_dout} = {a + 27'd2, d[31:16]};
		pred_pif = (sel == TGT_PIF);
		pred_cart = (sel == TGT_CART);
		if (pred_pif) begin
			pred_data = {d[7:0], d[15:8], d[23:16], d[31:24]};
			pred_addr = {ioctl_index[TGT_SEL_W], a[PIF_ADDR_W:2]};
		end else begin
			pred_data = d;
			pred_addr = a + CART_BASE;
		end
		if (pred_pif || pred_cart)
			exp_q.push_back({pred_cart, pred_addr, pred_data});
		@(posedge clk_1x);
		#2 {ioctl_wr, pred_pif, pred_cart} = 3'b000;
		@(posedge clk_1x);
		#1;
		while (ioctl_wait) begin
			@(posedge clk_1x);
			#1;
		end
	endtask

	task automatic run_download(input string name, input logic [INDEX_W-1:0] idx, input int n);
		int err0;
		err0 = errors;
		test_name = name;
		@(posedge clk_1x);
		#2 {ioctl_download, ioctl_index} = {1'b1, idx};
		for (int i = 0; i < n; i++)
			send_word({$urandom} & 27'h7ff_fffc, $urandom);
		repeat (3) @(posedge clk_1x);
		#2 ioctl_download = 1'b0;
		repeat (3) @(posedge clk_1x);
		tests++;
		$display("%s finished, %0d errors", name, errors - err0);
	endtask

	initial begin
		seed = 32'hb6eb_bf42;
		void'($urandom(seed));
		{reset_req, ioctl_download, ioctl_wr, pred_pif, pred_cart} = '0;
		{ioctl_index, ioctl_addr, ioctl_dout, pred_addr, pred_data} = '0;
		errors = 0;
		tests = 0;
		cycles = 0;
		test_name = "idle";
		repeat (12) @(posedge clk_1x);
		tests++;
		$display("idle finished, %0d errors", errors);
		run_download("pif_bank0", 8'h00, 8);
		run_download("pif_bank1", 8'h40, 8);
		run_download("cart", 8'h01, 8);
		run_download("cart_random_stall", 8'h01, 16);
		run_download("pif_after_cart", 8'h00, 4);
		#2 reset_req = 1'b1;
		repeat (2) @(posedge clk_1x);
		#2 reset_req = 1'b0;
		run_download("other_index", 8'h02, 4);
		if (exp_q.size() != 0)
			report_error($sformatf("%0d predicted writes never appeared", exp_q.size()));
		$display("%0d tests run, %0d errors", tests, errors);
		if (errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: compile.f
n64_load_pkg.sv
load_word_if.sv
ram_write_if.sv
load_capture.sv
load_router.sv
cart_ram_writer.sv
n64_loader_top.sv
tb_clock_gen.sv
n64_loader_tb.sv

// File: Makefile
VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing
TOP        ?= n64_loader_tb
RTL_TOP    ?= n64_loader_top
FILELIST   ?= compile.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "Test passed" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)
	$(VERILATOR) $(LINT_FLAGS) n64_load_pkg.sv load_word_if.sv ram_write_if.sv \
		load_capture.sv load_router.sv cart_ram_writer.sv n64_loader_top.sv \
		--top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
